//--- host_msg_pkg.sv
package host_msg_pkg;

    // ============================================================
    // Message and response framing
    // ============================================================
    localparam int MSG_LEN     = 64;
    localparam int RESP_LEN    = 64;
    localparam int MSG_TYPE_W  = 8;                     // Type byte on top of the message
    localparam int MSG_ARG_LEN = MSG_LEN - MSG_TYPE_W;  // 56-bit argument below it

    typedef logic [MSG_LEN-1:0]  msg_t;
    typedef logic [RESP_LEN-1:0] resp_t;

    // Bit 7 set means the host expects a response
    typedef enum logic [MSG_TYPE_W-1:0] {
        MSG_NOP            = 8'h00,
        MSG_LED_SET        = 8'h02,
        MSG_SD_BLOCK_CLEAR = 8'h05,
        MSG_ECHO           = 8'h81,
        MSG_SD_STATUS      = 8'h83,
        MSG_SD_READ_WORD   = 8'h84
    } msg_type_e;

    // ============================================================
    // Argument fields
    // ============================================================
    localparam int ARG_LED_LSB    = 0;
    localparam int ARG_LED_W      = 4;
    localparam int ARG_RD_IDX_LSB = 0;  // Width follows the buffer address

    // ============================================================
    // Response fields
    // ============================================================
    localparam int RESP_ECHO_LSB         = 0;   // Argument copied here, top byte zero
    localparam int RESP_STATUS_DONE_BIT  = 63;
    localparam int RESP_STATUS_COUNT_LSB = 8;   // Bits 13..8
    localparam int RESP_STATUS_MODE_LSB  = 0;   // Bits 3..0
    localparam int RESP_WORD_LSB         = 0;

endpackage

//--- sd_blk_pkg.sv
package sd_blk_pkg;

    // One 512-bit SD block held as 16-bit words
    localparam int BLK_WORDS = 32;

    // CMD6 status block carries the access mode in word 8
    localparam int CMD6_WORD_IDX   = 8;
    localparam int CMD6_NIBBLE_LSB = 8;    // Bits 11..8 of that word

    typedef logic [15:0]                  sd_word_t;
    typedef logic [$clog2(BLK_WORDS)-1:0] blk_addr_t;
    typedef logic [$clog2(BLK_WORDS):0]   blk_count_t;    // 0 to BLK_WORDS
    typedef logic [3:0]                   access_mode_t;

endpackage

//--- host_link_shifter.sv
`timescale 1ns/1ps

module host_link_shifter
    import host_msg_pkg::*;
#(
    parameter int RESP_TURNAROUND = 2   // Cycles from resp_valid to first driven bit
) (
    input  logic  sd_datInWrite_clk,
    input  logic  sd_datInWrite_rst_,
    input  logic  spi_data_in,
    output logic  msg_valid,
    output msg_t  msg,
    input  logic  resp_valid,
    input  resp_t resp,
    output logic  spi_data_out,
    output logic  spi_data_out_en
);

    // Counter must hold message length, response length and turnaround
    localparam int LEN_MAX = (MSG_LEN > RESP_LEN) ? MSG_LEN : RESP_LEN;
    localparam int CNT_MAX = (RESP_TURNAROUND > LEN_MAX) ? RESP_TURNAROUND : LEN_MAX;
    localparam int CNT_W   = $clog2(CNT_MAX);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MSG_IN,
        ST_TURNAROUND,
        ST_RESP_OUT
    } link_state_e;

    link_state_e      state;
    logic [CNT_W-1:0] bit_cnt;
    resp_t            resp_sr;

    // ============================================================
    // Link FSM
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            state     <= ST_IDLE;
            bit_cnt   <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (resp_valid) begin
                        // A turnaround below 2 collapses to the one-cycle minimum
                        if (RESP_TURNAROUND < 2) begin
                            state   <= ST_RESP_OUT;
                            bit_cnt <= CNT_W'(RESP_LEN - 1);
                        end else begin
                            state   <= ST_TURNAROUND;
                            bit_cnt <= CNT_W'(RESP_TURNAROUND - 2);
                        end
                    end else if (spi_data_in) begin   // Start bit, line idles low
                        state   <= ST_MSG_IN;
                        bit_cnt <= CNT_W'(MSG_LEN - 1);
                    end
                end
                ST_MSG_IN: begin
                    if (bit_cnt == '0) begin
                        msg_valid <= 1'b1;  // Last bit shifted in this edge
                        state     <= ST_IDLE;
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                ST_TURNAROUND: begin
                    if (bit_cnt == '0) begin
                        state   <= ST_RESP_OUT;
                        bit_cnt <= CNT_W'(RESP_LEN - 1);
                    end else begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                ST_RESP_OUT: begin
                    if (bit_cnt == '0) state <= ST_IDLE;
                    else               bit_cnt <= bit_cnt - 1'b1;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Shift registers, MSB first in both directions
    always_ff @(posedge sd_datInWrite_clk) begin
        if (state == ST_MSG_IN) msg <= {msg[MSG_LEN-2:0], spi_data_in};

        if (state == ST_IDLE && resp_valid) begin
            resp_sr <= resp;
        end else if (state == ST_RESP_OUT) begin
            resp_sr <= {resp_sr[RESP_LEN-2:0], 1'b0};
        end
    end

    assign spi_data_out_en = (state == ST_RESP_OUT);
    assign spi_data_out    = spi_data_out_en & resp_sr[RESP_LEN-1];  // Low when not driving

endmodule

//--- host_cmd_decoder.sv
`timescale 1ns/1ps

module host_cmd_decoder
    import host_msg_pkg::*;
    import sd_blk_pkg::*;
(
    input  logic                 sd_datInWrite_clk,
    input  logic                 sd_datInWrite_rst_,
    input  logic                 msg_valid,
    input  msg_t                 msg,
    output logic                 resp_valid,
    output resp_t                resp,
    output logic [ARG_LED_W-1:0] led,
    output logic                 blk_clear,
    output logic                 rd_req,
    output blk_addr_t            rd_addr,
    input  logic                 rd_valid,
    input  sd_word_t             rd_data,
    input  logic                 block_done,
    input  blk_count_t           word_count,
    input  access_mode_t         access_mode
);

    typedef enum logic {
        ST_IDLE,
        ST_READ_WAIT
    } dec_state_e;

    dec_state_e state;
    msg_type_e  msg_type;
    logic       resp_load;  // Response register takes a new value this cycle

    // Unknown codes fall to the default branch below
    assign msg_type = msg_type_e'(msg[MSG_LEN-1 -: MSG_TYPE_W]);

    // ============================================================
    // Control FSM
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            state      <= ST_IDLE;
            resp_valid <= 1'b0;
            blk_clear  <= 1'b0;
            rd_req     <= 1'b0;
            led        <= '0;
        end else begin
            resp_valid <= 1'b0;
            blk_clear  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (msg_valid) begin
                        case (msg_type)
                            MSG_LED_SET:        led <= msg[ARG_LED_LSB +: ARG_LED_W];
                            MSG_SD_BLOCK_CLEAR: blk_clear <= 1'b1;
                            MSG_ECHO,
                            MSG_SD_STATUS:      resp_valid <= 1'b1;
                            MSG_SD_READ_WORD: begin
                                rd_req <= 1'b1;     // Held until the arbiter answers
                                state  <= ST_READ_WAIT;
                            end
                            default: ;              // Nop and unknown types
                        endcase
                    end
                end
                ST_READ_WAIT: begin
                    if (rd_valid) begin
                        rd_req     <= 1'b0;
                        resp_valid <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign resp_load = (state == ST_IDLE && msg_valid) || (state == ST_READ_WAIT && rd_valid);

    // ============================================================
    // Response and read address
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk) begin
        if (resp_load) begin
            resp <= '0;
            if (state == ST_READ_WAIT) begin
                resp[RESP_WORD_LSB +: $bits(sd_word_t)] <= rd_data;
            end else if (msg_type == MSG_ECHO) begin
                resp[RESP_ECHO_LSB +: MSG_ARG_LEN] <= msg[MSG_ARG_LEN-1:0];
            end else if (msg_type == MSG_SD_STATUS) begin
                resp[RESP_STATUS_DONE_BIT]                          <= block_done;
                resp[RESP_STATUS_COUNT_LSB +: $bits(blk_count_t)]   <= word_count;
                resp[RESP_STATUS_MODE_LSB +: $bits(access_mode_t)]  <= access_mode;
            end
        end

        if (state == ST_IDLE && msg_valid && msg_type == MSG_SD_READ_WORD) begin
            rd_addr <= msg[ARG_RD_IDX_LSB +: $bits(blk_addr_t)];
        end
    end

endmodule

//--- sd_datin_capture.sv
`timescale 1ns/1ps

module sd_datin_capture
    import sd_blk_pkg::*;
(
    input  logic         sd_datInWrite_clk,
    input  logic         sd_datInWrite_rst_,
    input  logic         sd_datin_trigger,
    input  sd_word_t     sd_datin_data,
    output logic         sd_datin_ready,
    input  logic         blk_clear,
    output logic         wr_req,
    output blk_addr_t    wr_addr,
    output sd_word_t     wr_data,
    output logic         block_done,
    output blk_count_t   word_count,
    output access_mode_t access_mode
);

    logic accept;

    // Triggers while the block is full are dropped
    assign accept = sd_datin_trigger && sd_datin_ready;

    // Word goes to the buffer in its own trigger cycle
    assign wr_req  = accept;
    assign wr_addr = word_count[$bits(blk_addr_t)-1:0];
    assign wr_data = sd_datin_data;

    // ============================================================
    // Word counter and CMD6 access mode
    // ============================================================
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            word_count  <= '0;
            access_mode <= '0;
        end else begin
            if (blk_clear) begin
                word_count <= '0;   // Access mode survives a clear
            end else if (accept) begin
                word_count <= word_count + 1'b1;
            end

            if (accept && word_count == blk_count_t'(CMD6_WORD_IDX)) begin
                access_mode <= sd_datin_data[CMD6_NIBBLE_LSB +: $bits(access_mode_t)];
            end
        end
    end

    // Both follow the registered count, so they move one cycle after the last word
    assign block_done     = (word_count == blk_count_t'(BLK_WORDS));
    assign sd_datin_ready = !block_done;

endmodule

//--- blk_buf_arbiter.sv
`timescale 1ns/1ps

module blk_buf_arbiter
    import sd_blk_pkg::*;
(
    input  logic      sd_datInWrite_clk,
    input  logic      sd_datInWrite_rst_,
    input  logic      wr_req,
    input  blk_addr_t wr_addr,
    input  sd_word_t  wr_data,
    input  logic      rd_req,
    input  blk_addr_t rd_addr,
    output logic      rd_valid,
    output sd_word_t  rd_data,
    output logic      ram_we,
    output blk_addr_t ram_addr,
    output sd_word_t  ram_wdata,
    input  sd_word_t  ram_rdata
);

    logic rd_grant;

    // Writes always win. A read also waits while its result is on the way back
    assign rd_grant = rd_req && !wr_req && !rd_valid;

    // ============================================================
    // Port mux
    // ============================================================
    assign ram_we    = wr_req;
    assign ram_addr  = wr_req ? wr_addr : rd_addr;
    assign ram_wdata = wr_data;

    // Read in flight, valid the cycle after the grant
    always_ff @(posedge sd_datInWrite_clk or negedge sd_datInWrite_rst_) begin
        if (!sd_datInWrite_rst_) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_grant;
        end
    end

    // RAM output register holds the granted word during rd_valid
    assign rd_data = ram_rdata;

endmodule

//--- blk_buf_ram.sv
`timescale 1ns/1ps

module blk_buf_ram
    import sd_blk_pkg::*;
(
    input  logic      sd_datInWrite_clk,
    input  logic      ram_we,
    input  blk_addr_t ram_addr,
    input  sd_word_t  ram_wdata,
    output sd_word_t  ram_rdata
);

    sd_word_t mem [BLK_WORDS];

    // Single port, old data on a write cycle
    always_ff @(posedge sd_datInWrite_clk) begin
        if (ram_we) begin
            mem[ram_addr] <= ram_wdata;
        end
        ram_rdata <= mem[ram_addr];
    end

endmodule

//--- ice_app_top.sv
`timescale 1ns/1ps

module ice_app_top
    import host_msg_pkg::*;
    import sd_blk_pkg::*;
#(
    parameter int RESP_TURNAROUND = 2
) (
    input  logic       sd_datInWrite_clk,
    input  logic       sd_datInWrite_rst_,
    input  logic       spi_data_in,
    output logic       spi_data_out,
    output logic       spi_data_out_en,
    output logic [3:0] led,
    input  logic       sd_datin_trigger,
    input  sd_word_t   sd_datin_data,
    output logic       sd_datin_ready
);

    // Host link to decoder
    logic         msg_valid;
    msg_t         msg;
    logic         resp_valid;
    resp_t        resp;

    // Capture status and buffer traffic
    logic         blk_clear;
    logic         block_done;
    blk_count_t   word_count;
    access_mode_t access_mode;
    logic         wr_req;
    blk_addr_t    wr_addr;
    sd_word_t     wr_data;
    logic         rd_req;
    blk_addr_t    rd_addr;
    logic         rd_valid;
    sd_word_t     rd_data;

    // RAM port
    logic         ram_we;
    blk_addr_t    ram_addr;
    sd_word_t     ram_wdata;
    sd_word_t     ram_rdata;

    // ============================================================
    // Host command path
    // ============================================================
    host_link_shifter #(
        .RESP_TURNAROUND(RESP_TURNAROUND)
    ) i_host_link_shifter (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .sd_datInWrite_rst_(sd_datInWrite_rst_),
        .spi_data_in       (spi_data_in),
        .msg_valid         (msg_valid),
        .msg               (msg),
        .resp_valid        (resp_valid),
        .resp              (resp),
        .spi_data_out      (spi_data_out),
        .spi_data_out_en   (spi_data_out_en)
    );

    host_cmd_decoder i_host_cmd_decoder (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .sd_datInWrite_rst_(sd_datInWrite_rst_),
        .msg_valid         (msg_valid),
        .msg               (msg),
        .resp_valid        (resp_valid),
        .resp              (resp),
        .led               (led),
        .blk_clear         (blk_clear),
        .rd_req            (rd_req),
        .rd_addr           (rd_addr),
        .rd_valid          (rd_valid),
        .rd_data           (rd_data),
        .block_done        (block_done),
        .word_count        (word_count),
        .access_mode       (access_mode)
    );

    // ============================================================
    // SD data-in and block buffer
    // ============================================================
    sd_datin_capture i_sd_datin_capture (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .sd_datInWrite_rst_(sd_datInWrite_rst_),
        .sd_datin_trigger  (sd_datin_trigger),
        .sd_datin_data     (sd_datin_data),
        .sd_datin_ready    (sd_datin_ready),
        .blk_clear         (blk_clear),
        .wr_req            (wr_req),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .block_done        (block_done),
        .word_count        (word_count),
        .access_mode       (access_mode)
    );

    blk_buf_arbiter i_blk_buf_arbiter (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .sd_datInWrite_rst_(sd_datInWrite_rst_),
        .wr_req            (wr_req),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .rd_req            (rd_req),
        .rd_addr           (rd_addr),
        .rd_valid          (rd_valid),
        .rd_data           (rd_data),
        .ram_we            (ram_we),
        .ram_addr          (ram_addr),
        .ram_wdata         (ram_wdata),
        .ram_rdata         (ram_rdata)
    );

    blk_buf_ram i_blk_buf_ram (
        .sd_datInWrite_clk(sd_datInWrite_clk),
        .ram_we           (ram_we),
        .ram_addr         (ram_addr),
        .ram_wdata        (ram_wdata),
        .ram_rdata        (ram_rdata)
    );

endmodule

//--- tb_ice_app.sv
`timescale 1ns/1ps

module tb_ice_app;

    localparam int NSTEPS       = 14;
    localparam int CYCLE_LIMIT  = NSTEPS * 200;
    localparam int QUIET_CYCLES = 200;     // Window in which no response may start

    // Step kinds
    localparam logic [1:0] K_MSG      = 2'd0;
    localparam logic [1:0] K_BLOCK    = 2'd1;  // One word per cycle
    localparam logic [1:0] K_BLOCK_RD = 2'd2;  // Word every 3 cycles, message sent alongside

    // Message type codes
    localparam logic [7:0] T_NOP     = 8'h00;
    localparam logic [7:0] T_LED     = 8'h02;
    localparam logic [7:0] T_CLEAR   = 8'h05;
    localparam logic [7:0] T_ECHO    = 8'h81;
    localparam logic [7:0] T_STATUS  = 8'h83;
    localparam logic [7:0] T_READ    = 8'h84;
    localparam logic [7:0] T_UNKNOWN = 8'h90;  // Response bit set but no such type

    typedef struct packed {
        logic [1:0]  kind;
        logic        blk;
        logic [63:0] msg;
        logic        has_resp;
        logic [63:0] resp;
        logic [3:0]  led;
        logic        ready;
    } step_t;

    logic        sd_datInWrite_clk;
    logic        sd_datInWrite_rst_;
    logic        spi_data_in;
    logic        spi_data_out;
    logic        spi_data_out_en;
    logic [3:0]  led;
    logic        sd_datin_trigger;
    logic [15:0] sd_datin_data;
    logic        sd_datin_ready;

    step_t       steps [NSTEPS];
    logic [15:0] blk_words [2][32];   // Model of both streamed blocks
    integer      seed;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    ice_app_top #(
        .RESP_TURNAROUND(2)
    ) i_ice_app_top (
        .sd_datInWrite_clk (sd_datInWrite_clk),
        .sd_datInWrite_rst_(sd_datInWrite_rst_),
        .spi_data_in       (spi_data_in),
        .spi_data_out      (spi_data_out),
        .spi_data_out_en   (spi_data_out_en),
        .led               (led),
        .sd_datin_trigger  (sd_datin_trigger),
        .sd_datin_data     (sd_datin_data),
        .sd_datin_ready    (sd_datin_ready)
    );

    always #5 sd_datInWrite_clk = ~sd_datInWrite_clk;

    always @(posedge sd_datInWrite_clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ============================================================
    // Checks and bus helpers
    // ============================================================
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp, input int step);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail step %0d: %s = %h, expected %h", step, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Error: %s", what);
        end
    endtask

    task automatic next_cycle();
        @(posedge sd_datInWrite_clk);
        #1;  // Outputs settled, inputs change here
    endtask

    task automatic send_message(input logic [63:0] m);
        spi_data_in = 1'b1;  // Start bit
        next_cycle();
        for (int i = 63; i >= 0; i--) begin
            spi_data_in = m[i];
            next_cycle();
        end
        spi_data_in = 1'b0;
    endtask

    task automatic collect_response(output logic [63:0] r, output int nbits);
        r     = '0;
        nbits = 0;
        while (!spi_data_out_en) next_cycle();
        while (spi_data_out_en) begin
            r = {r[62:0], spi_data_out};  // MSB first
            nbits++;
            next_cycle();
        end
    endtask

    task automatic watch_quiet(input int ncycles, input string what);
        logic seen;
        seen = 1'b0;
        repeat (ncycles) begin
            if (spi_data_out_en) seen = 1'b1;
            next_cycle();
        end
        check_true(!seen, what);
    endtask

    task automatic stream_block(input int b, input int gap);
        for (int w = 0; w < 32; w++) begin
            sd_datin_trigger = 1'b1;
            sd_datin_data    = blk_words[b][w];
            next_cycle();
            sd_datin_trigger = 1'b0;
            repeat (gap - 1) next_cycle();
        end
    endtask

    task automatic exchange(input int s);
        logic [63:0] r;
        int          nbits;
        send_message(steps[s].msg);
        if (steps[s].has_resp) begin
            collect_response(r, nbits);
            check_value("spi_data_out response", r, steps[s].resp, s);
            check_value("spi_data_out_en cycles", 64'(nbits), 64'd64, s);
        end else begin
            watch_quiet(QUIET_CYCLES, $sformatf(
                "step %0d: spi_data_out_en rose although no response was expected", s));
        end
    endtask

    // ============================================================
    // Expected values from the response layout
    // ============================================================
    function automatic logic [63:0] status_resp(input logic done, input logic [5:0] count,
                                                input logic [3:0] mode);
        return {done, 49'd0, count, 4'd0, mode};  // 63 done, 13..8 count, 3..0 mode
    endfunction

    function automatic logic [63:0] read_msg(input logic [4:0] idx);
        return {T_READ, 51'd0, idx};
    endfunction

    function automatic step_t make_step(input logic [1:0] kind, input logic blk,
                                        input logic [63:0] msg, input logic has_resp,
                                        input logic [63:0] resp, input logic [3:0] led_exp,
                                        input logic ready_exp);
        return {kind, blk, msg, has_resp, resp, led_exp, ready_exp};
    endfunction

    task automatic build_table();
        logic [3:0] mode0;
        logic [3:0] mode1;
        seed = 47;
        for (int b = 0; b < 2; b++) begin
            for (int w = 0; w < 32; w++) blk_words[b][w] = 16'($random(seed));
        end
        // First block must carry an access mode other than the reset value
        if (blk_words[0][8][11:8] == 4'h0) begin
            blk_words[0][8][8] = 1'b1;
        end
        // Second block must carry a different access mode
        if (blk_words[1][8][11:8] == blk_words[0][8][11:8]) begin
            blk_words[1][8][11] = ~blk_words[1][8][11];
        end
        mode0 = blk_words[0][8][11:8];
        mode1 = blk_words[1][8][11:8];

        steps[0]  = make_step(K_MSG, 0, {T_ECHO, 56'h12_3456_789A_BCDE}, 1,
                              {8'h00, 56'h12_3456_789A_BCDE}, 4'h0, 1);
        steps[1]  = make_step(K_MSG, 0, {T_NOP, 56'hA5_A5A5_A5A5_A5A5}, 0, '0, 4'h0, 1);
        steps[2]  = make_step(K_MSG, 0, {T_UNKNOWN, 56'h1}, 0, '0, 4'h0, 1);
        steps[3]  = make_step(K_MSG, 0, {T_LED, 56'hFF_FFFF_FFFF_FFFA}, 0, '0, 4'hA, 1);
        steps[4]  = make_step(K_BLOCK, 0, '0, 0, '0, 4'hA, 0);
        steps[5]  = make_step(K_MSG, 0, {T_STATUS, 56'd0}, 1, status_resp(1, 32, mode0), 4'hA, 0);
        steps[6]  = make_step(K_MSG, 0, read_msg(0), 1, {48'd0, blk_words[0][0]}, 4'hA, 0);
        steps[7]  = make_step(K_MSG, 0, read_msg(8), 1, {48'd0, blk_words[0][8]}, 4'hA, 0);
        steps[8]  = make_step(K_MSG, 0, read_msg(31), 1, {48'd0, blk_words[0][31]}, 4'hA, 0);
        steps[9]  = make_step(K_MSG, 0, {T_CLEAR, 56'd0}, 0, '0, 4'hA, 1);
        steps[10] = make_step(K_MSG, 0, {T_STATUS, 56'd0}, 1, status_resp(0, 0, mode0), 4'hA, 1);
        // Word 2 lands long before the read decodes, later words still contend
        steps[11] = make_step(K_BLOCK_RD, 1, read_msg(2), 1, {48'd0, blk_words[1][2]}, 4'hA, 0);
        steps[12] = make_step(K_MSG, 0, {T_STATUS, 56'd0}, 1, status_resp(1, 32, mode1), 4'hA, 0);
        steps[13] = make_step(K_MSG, 0, {T_ECHO, {56{1'b1}}}, 1, {8'h00, {56{1'b1}}}, 4'hA, 0);
    endtask

    task automatic run_step(input int s);
        step_t st;
        st = steps[s];
        case (st.kind)
            K_BLOCK: stream_block(st.blk, 1);
            K_BLOCK_RD: begin
                fork
                    stream_block(st.blk, 3);
                    exchange(s);
                join
            end
            default: exchange(s);
        endcase
        next_cycle();
        check_value("led", {60'd0, led}, {60'd0, st.led}, s);
        check_value("sd_datin_ready", {63'd0, sd_datin_ready}, {63'd0, st.ready}, s);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        sd_datInWrite_clk  = 1'b0;
        sd_datInWrite_rst_ = 1'b0;
        spi_data_in        = 1'b0;
        sd_datin_trigger   = 1'b0;
        sd_datin_data      = '0;
        build_table();

        repeat (4) @(posedge sd_datInWrite_clk);
        #1 sd_datInWrite_rst_ = 1'b1;
        next_cycle();

        // Idle state after reset
        check_value("led", {60'd0, led}, 64'd0, -1);
        check_value("sd_datin_ready", {63'd0, sd_datin_ready}, 64'd1, -1);
        watch_quiet(20, "spi_data_out_en rose after reset with the line idle");

        for (int s = 0; s < NSTEPS; s++) run_step(s);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- files.f
host_msg_pkg.sv
sd_blk_pkg.sv
host_link_shifter.sv
host_cmd_decoder.sv
sd_datin_capture.sv
blk_buf_arbiter.sv
blk_buf_ram.sv
ice_app_top.sv
tb_ice_app.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_ice_app -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0
